// File: design/resolver_config.svh
// Compile-time timing, resolution and buffering values for the resolver interface
// Counts are in clock cycles unless noted
`ifndef RESOLVER_CONFIG_SVH
`define RESOLVER_CONFIG_SVH

// Clock cycles per half SCLK period
`define RES_SCLK_DIV 4

// Width of the SAMPLE low pulse
`define RES_SAMPLE_CYCLES 4

// Wait after SAMPLE rises before the serial frame starts
`define RES_SETTLE_CYCLES 6

// Cycles between two angle reads
`define RES_ANGLE_PERIOD 400

// One speed read follows every this many angle reads
`define RES_SPEED_EVERY 4

// RES1/RES0 code, 2'b11 selects 16-bit resolution
`define RES_RESOLUTION 2'b11

// Entries in the sample FIFO
`define RES_FIFO_DEPTH 4

`endif

// File: design/resolver_pkg.sv
// Types shared by the resolver interface RTL
// Converter data words, fault byte, FIFO entry layout and reader FSM states
package resolver_pkg;

    // One 16-bit converter data word
    // Angle is unsigned, speed is two's complement
    typedef logic [15:0] res_word_t;

    // Fault register that trails every data word in a frame
    typedef logic [7:0] fault_t;

    // Tag telling which register a sample was read from
    typedef enum logic {
        kind_angle = 1'b0,
        kind_speed = 1'b1
    } sample_kind_t;

    // One FIFO entry, kind in the MSB, then the word, then the fault byte
    typedef struct packed {
        sample_kind_t kind;
        res_word_t    word;
        fault_t       fault;
    } sample_entry_t;

    // Signed count of whole shaft revolutions
    typedef logic signed [15:0] turns_t;

    // Reader FSM states
    typedef enum logic [2:0] {
        rd_idle,
        rd_sample_low,
        rd_sample_wait,
        rd_shift,
        rd_push
    } reader_state_t;

endpackage

// File: design/read_scheduler.sv
// Periodic read request generator
// Angle read strobes on a fixed period plus one speed strobe per group of angle reads
`timescale 1ns/10ps
`include "resolver_config.svh"

module read_scheduler (
    input  logic clock,
    input  logic rst_n,
    input  logic enable,
    output logic read_angle,
    output logic read_speed
);

    localparam int PERIOD_W = $clog2(`RES_ANGLE_PERIOD + 1);
    localparam int EVERY_W  = $clog2(`RES_SPEED_EVERY + 1);

    logic [PERIOD_W-1:0] period_cnt;
    logic [EVERY_W-1:0]  angle_cnt;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            period_cnt <= '0;
            angle_cnt  <= '0;
            read_angle <= 1'b0;
            read_speed <= 1'b0;
        end else begin
            read_angle <= 1'b0;
            read_speed <= 1'b0;
            // The period restarts from zero each time enable goes low
            if (!enable) begin
                period_cnt <= '0;
            end else if (period_cnt == PERIOD_W'(`RES_ANGLE_PERIOD - 1)) begin
                period_cnt <= '0;
                read_angle <= 1'b1;
            end else begin
                period_cnt <= period_cnt + 1'b1;
            end
            // Count issued angle strobes, the last of a group is chased by a speed strobe
            if (read_angle) begin
                if (angle_cnt == EVERY_W'(`RES_SPEED_EVERY - 1)) begin
                    angle_cnt  <= '0;
                    read_speed <= 1'b1;
                end else begin
                    angle_cnt <= angle_cnt + 1'b1;
                end
            end
        end
    end

    // The reader would serve both, but the speed strobe is meant to trail the angle one
    a_no_double_read: assert property (@(posedge clock) disable iff (!rst_n)
        !(read_angle && read_speed))
        else $error("read_angle and read_speed asserted together");

endmodule

// File: design/ad2s1210_reader.sv
// AD2S1210 pin sequencer and serial frame receiver
// Runs SAMPLE, address select and a divided SCLK, then pushes a tagged 24-bit frame
`timescale 1ns/10ps
`include "resolver_config.svh"

module ad2s1210_reader (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        read_angle,
    input  logic                        read_speed,
    input  logic                        sdo,
    output logic                        sample_n,
    output logic                        wr_n,
    output logic                        sclk,
    output logic                        sdi,
    output logic                        a1,
    output logic                        a0,
    output logic                        re1,
    output logic                        re0,
    output logic                        res_reset_n,
    output logic                        push,
    output resolver_pkg::sample_entry_t push_entry
);

    resolver_pkg::reader_state_t state;
    resolver_pkg::sample_kind_t  cur_kind;
    resolver_pkg::sample_kind_t  next_kind;

    logic        pending_angle;
    logic        pending_speed;
    logic        start_frame;
    logic        rise_edge;
    logic [1:0]  addr;
    logic [7:0]  wait_cnt;
    logic [7:0]  div_cnt;
    logic [4:0]  bit_cnt;
    logic [23:0] shift_reg;

    // Angle always wins when both requests are pending
    assign next_kind = pending_angle ? resolver_pkg::kind_angle : resolver_pkg::kind_speed;
    // A new frame may start from idle or straight out of the push cycle
    assign start_frame = (pending_angle || pending_speed) &&
                         (state == resolver_pkg::rd_idle || state == resolver_pkg::rd_push);
    // Last cycle of a low SCLK half, the next edge raises SCLK and samples SDO
    assign rise_edge = (state == resolver_pkg::rd_shift) && !sclk &&
                       (div_cnt == 8'(`RES_SCLK_DIV - 1));

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state         <= resolver_pkg::rd_idle;
            cur_kind      <= resolver_pkg::kind_angle;
            pending_angle <= 1'b0;
            pending_speed <= 1'b0;
            addr          <= 2'b00;
            sample_n      <= 1'b1;
            wr_n          <= 1'b1;
            sclk          <= 1'b1;
            wait_cnt      <= '0;
            div_cnt       <= '0;
            bit_cnt       <= '0;
        end else begin
            // Requests are remembered until their frame starts
            pending_angle <= pending_angle | read_angle;
            pending_speed <= pending_speed | read_speed;
            case (state)
                resolver_pkg::rd_sample_low: begin
                    if (wait_cnt == 8'(`RES_SAMPLE_CYCLES - 1)) begin
                        sample_n <= 1'b1;
                        wait_cnt <= '0;
                        state    <= resolver_pkg::rd_sample_wait;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                resolver_pkg::rd_sample_wait: begin
                    // Converter latches the result on SAMPLE, give it time to settle
                    if (wait_cnt == 8'(`RES_SETTLE_CYCLES - 1)) begin
                        wr_n    <= 1'b0;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= resolver_pkg::rd_shift;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                resolver_pkg::rd_shift: begin
                    // Each bit is one low and one high SCLK half, RES_SCLK_DIV cycles each
                    if (div_cnt == 8'(`RES_SCLK_DIV - 1)) begin
                        div_cnt <= '0;
                        sclk    <= ~sclk;
                        if (rise_edge) begin
                            if (bit_cnt == 5'd23) begin
                                wr_n  <= 1'b1;
                                state <= resolver_pkg::rd_push;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                resolver_pkg::rd_push: state <= resolver_pkg::rd_idle;
                default: state <= resolver_pkg::rd_idle;
            endcase
            // Frame start overrides the idle return above
            if (start_frame) begin
                state    <= resolver_pkg::rd_sample_low;
                cur_kind <= next_kind;
                addr     <= (next_kind == resolver_pkg::kind_speed) ? 2'b01 : 2'b00;
                sample_n <= 1'b0;
                wait_cnt <= '0;
                if (next_kind == resolver_pkg::kind_angle) begin
                    pending_angle <= read_angle;
                end else begin
                    pending_speed <= read_speed;
                end
            end
        end
    end

    // The converter moves SDO after each falling SCLK, so it is stable at the rise
    always_ff @(posedge clock) begin
        if (rise_edge) begin
            shift_reg <= {shift_reg[22:0], sdo};
        end
    end

    assign push             = (state == resolver_pkg::rd_push);
    assign push_entry.kind  = cur_kind;
    assign push_entry.word  = shift_reg[23:8];
    assign push_entry.fault = shift_reg[7:0];

    assign {a1, a0}    = addr;
    assign {re1, re0}  = `RES_RESOLUTION;
    // Configuration writes are not supported
    assign sdi         = 1'b0;
    assign res_reset_n = rst_n;

    a_addr_stable: assert property (@(posedge clock) disable iff (!rst_n)
        !wr_n |=> wr_n || $stable({a1, a0}))
        else $error("a1/a0 changed during a frame");

    a_sclk_idle: assert property (@(posedge clock) disable iff (!rst_n)
        wr_n |-> sclk)
        else $error("sclk low outside a frame");

endmodule

// File: design/sample_fifo.sv
// Small synchronous FIFO of tagged converter samples
// Show-ahead read port and a sticky overflow flag for dropped pushes
`timescale 1ns/10ps
`include "resolver_config.svh"

module sample_fifo (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        push,
    input  resolver_pkg::sample_entry_t push_entry,
    input  logic                        pop,
    output resolver_pkg::sample_entry_t pop_entry,
    output logic                        not_empty,
    output logic                        overflow
);

    localparam int DEPTH = `RES_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    resolver_pkg::sample_entry_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == (PTR_W + 1)'(DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && not_empty;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            // Pointers wrap explicitly so any depth works
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + do_push - do_pop;
            // Once a sample is lost the flag stays up until reset
            if (push && full) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    assign pop_entry = mem[rd_ptr];
    assign not_empty = (count != '0);

    a_no_pop_empty: assert property (@(posedge clock) disable iff (!rst_n)
        pop |-> not_empty)
        else $error("pop while FIFO empty");

endmodule

// File: design/position_tracker.sv
// Sample consumer that unpacks FIFO entries into shaft outputs
// Angle and speed words, fault byte, valid strobes and a signed turn count
`timescale 1ns/10ps

module position_tracker (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        not_empty,
    input  resolver_pkg::sample_entry_t pop_entry,
    output logic                        pop,
    output resolver_pkg::res_word_t     angle,
    output resolver_pkg::res_word_t     speed,
    output resolver_pkg::turns_t        turns,
    output resolver_pkg::fault_t        fault,
    output logic                        angle_valid,
    output logic                        speed_valid
);

    logic is_angle;
    logic angle_seen;
    logic wrap_up;
    logic wrap_down;

    // One entry per cycle, far faster than the reader can fill the FIFO
    assign pop      = not_empty;
    assign is_angle = (pop_entry.kind == resolver_pkg::kind_angle);

    // Crossing zero between the top and bottom quadrants counts as one turn
    assign wrap_up   = (angle[15:14] == 2'b11) && (pop_entry.word[15:14] == 2'b00);
    assign wrap_down = (angle[15:14] == 2'b00) && (pop_entry.word[15:14] == 2'b11);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            turns       <= '0;
            angle_seen  <= 1'b0;
            angle_valid <= 1'b0;
            speed_valid <= 1'b0;
        end else begin
            angle_valid <= pop && is_angle;
            speed_valid <= pop && !is_angle;
            if (pop && is_angle) begin
                angle_seen <= 1'b1;
                // No previous angle yet, so the first one cannot be a wrap
                if (angle_seen && wrap_up) begin
                    turns <= turns + 16'sd1;
                end else if (angle_seen && wrap_down) begin
                    turns <= turns - 16'sd1;
                end
            end
        end
    end

    // Output words only change when their valid strobe follows
    always_ff @(posedge clock) begin
        if (pop) begin
            fault <= pop_entry.fault;
            if (is_angle) begin
                angle <= pop_entry.word;
            end else begin
                speed <= pop_entry.word;
            end
        end
    end

endmodule

// File: design/resolver_top.sv
// Resolver interface top level
// Scheduler and reader feed the FIFO, the tracker drains it into shaft outputs
`timescale 1ns/10ps

module resolver_top (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    enable,
    input  logic                    sdo,
    output logic                    sample_n,
    output logic                    wr_n,
    output logic                    sclk,
    output logic                    sdi,
    output logic                    a1,
    output logic                    a0,
    output logic                    re1,
    output logic                    re0,
    output logic                    res_reset_n,
    output resolver_pkg::res_word_t angle,
    output resolver_pkg::res_word_t speed,
    output resolver_pkg::turns_t    turns,
    output resolver_pkg::fault_t    fault,
    output logic                    angle_valid,
    output logic                    speed_valid,
    output logic                    overflow
);

    logic                        read_angle;
    logic                        read_speed;
    logic                        push;
    logic                        pop;
    logic                        not_empty;
    resolver_pkg::sample_entry_t push_entry;
    resolver_pkg::sample_entry_t pop_entry;

    read_scheduler u_scheduler (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .read_angle(read_angle), .read_speed(read_speed)
    );

    // Converter pins go straight out from the reader
    ad2s1210_reader u_reader (
        .clock(clock), .rst_n(rst_n), .read_angle(read_angle), .read_speed(read_speed),
        .sdo(sdo), .sample_n(sample_n), .wr_n(wr_n), .sclk(sclk), .sdi(sdi),
        .a1(a1), .a0(a0), .re1(re1), .re0(re0), .res_reset_n(res_reset_n),
        .push(push), .push_entry(push_entry)
    );

    sample_fifo u_fifo (
        .clock(clock), .rst_n(rst_n), .push(push), .push_entry(push_entry),
        .pop(pop), .pop_entry(pop_entry), .not_empty(not_empty), .overflow(overflow)
    );

    position_tracker u_tracker (
        .clock(clock), .rst_n(rst_n), .not_empty(not_empty), .pop_entry(pop_entry),
        .pop(pop), .angle(angle), .speed(speed), .turns(turns), .fault(fault),
        .angle_valid(angle_valid), .speed_valid(speed_valid)
    );

endmodule

// File: verification/ad2s1210_model.sv
// Behavioral AD2S1210 serial port model
// Holds loaded angle, speed and fault values and answers 24-bit frames on sdo
`timescale 1ns/10ps

module ad2s1210_model (
    input  logic                    sample_n,
    input  logic                    wr_n,
    input  logic                    sclk,
    input  logic                    a1,
    input  logic                    a0,
    input  resolver_pkg::res_word_t angle_value,
    input  resolver_pkg::res_word_t speed_value,
    input  resolver_pkg::fault_t    fault_value,
    output logic                    sdo
);

    resolver_pkg::res_word_t hold_angle;
    resolver_pkg::res_word_t hold_speed;
    resolver_pkg::fault_t    hold_fault;

    logic [23:0] frame = '0;
    logic [4:0]  fall_cnt = '0;
    logic        out_bit = 1'b0;

    // SAMPLE freezes both result registers and the fault byte at once
    always @(negedge sample_n) begin
        hold_angle <= angle_value;
        hold_speed <= speed_value;
        hold_fault <= fault_value;
    end

    // The address pins pick which held register goes out in this frame
    always @(negedge wr_n) begin
        frame <= ({a1, a0} == 2'b01) ? {hold_speed, hold_fault} : {hold_angle, hold_fault};
    end

    // Each falling SCLK inside a frame presents the next bit, MSB first
    always @(negedge sclk or posedge wr_n) begin
        if (wr_n) begin
            fall_cnt <= '0;
            out_bit  <= 1'b0;
        end else begin
            out_bit  <= frame[23 - fall_cnt];
            fall_cnt <= fall_cnt + 1'b1;
        end
    end

    assign sdo = out_bit;

endmodule

// File: verification/resolver_tb.sv
// Testbench for the resolver interface top level
// Clock, reset, LFSR-picked converter values, output and pin checks, closing report
`timescale 1ns/10ps
`include "resolver_config.svh"

module resolver_tb;

    localparam int          ANGLE_UPDATES = 16;
    localparam int          RANDOM_STEPS  = 8;
    localparam int          WAIT_LIMIT    = 2 * `RES_ANGLE_PERIOD + 500;
    localparam logic [31:0] LFSR_SEED     = 32'ha15d_d9a0;
    localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003;

    logic clock;
    logic rst_n;
    logic enable;
    logic sdo;
    logic sample_n;
    logic wr_n;
    logic sclk;
    logic sdi;
    logic a1;
    logic a0;
    logic re1;
    logic re0;
    logic res_reset_n;
    logic angle_valid;
    logic speed_valid;
    logic overflow;

    resolver_pkg::res_word_t angle;
    resolver_pkg::res_word_t speed;
    resolver_pkg::turns_t    turns;
    resolver_pkg::fault_t    fault;

    // Values the converter model reports and what it held at the last SAMPLE
    resolver_pkg::res_word_t model_angle;
    resolver_pkg::res_word_t model_speed;
    resolver_pkg::fault_t    model_fault;
    resolver_pkg::res_word_t cap_angle;
    resolver_pkg::res_word_t cap_speed;
    resolver_pkg::fault_t    cap_fault;

    // Expected frames in read order with the word in the upper 16 bits and the fault below
    logic [23:0] angle_q[$];
    logic [23:0] speed_q[$];

    logic [31:0]             lfsr;
    resolver_pkg::res_word_t prev_angle;
    logic                    have_prev = 1'b0;
    logic                    prev_wr_n = 1'b1;
    logic                    prev_sample_n = 1'b1;
    logic                    prev_overflow = 1'b0;
    logic                    sample_done = 1'b0;
    logic [1:0]              prev_addr = 2'b00;

    int value_errors = 0;
    int other_errors = 0;
    int timeouts = 0;
    int speed_updates = 0;
    int angles_since_speed = 0;
    int wraps_up = 0;
    int wraps_down = 0;
    int exp_turns = 0;

    resolver_top DUT (
        .clock(clock), .rst_n(rst_n), .enable(enable), .sdo(sdo),
        .sample_n(sample_n), .wr_n(wr_n), .sclk(sclk), .sdi(sdi), .a1(a1), .a0(a0),
        .re1(re1), .re0(re0), .res_reset_n(res_reset_n), .angle(angle), .speed(speed),
        .turns(turns), .fault(fault), .angle_valid(angle_valid),
        .speed_valid(speed_valid), .overflow(overflow)
    );

    ad2s1210_model u_model (
        .sample_n(sample_n), .wr_n(wr_n), .sclk(sclk), .a1(a1), .a0(a0),
        .angle_value(model_angle), .speed_value(model_speed), .fault_value(model_fault),
        .sdo(sdo)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        value_errors++;
        $display("FAIL t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
    endtask

    task automatic report_problem(input string text);
        other_errors++;
        $display("t=%0t %s", $time, text);
    endtask

    // Galois LFSR stepped once for every bit handed out
    function automatic logic [31:0] next_bits(input int count);
        logic [31:0] value;
        int          n;
        value = '0;
        for (n = 0; n < count; n++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return value;
    endfunction

    // Early steps are random, later ones hop between the top and bottom quadrants
    task automatic load_model_values(input int step);
        if (step < RANDOM_STEPS) begin
            model_angle = 16'(next_bits(16));
        end else if (step % 2 == 0) begin
            model_angle = {2'b11, 14'(next_bits(14))};
        end else begin
            model_angle = {2'b00, 14'(next_bits(14))};
        end
        model_speed = 16'(next_bits(16));
        model_fault = 8'(next_bits(8));
    endtask

    task automatic check_idle_state();
        assert (!angle_valid) else report_mismatch("angle_valid", 0, angle_valid);
        assert (!speed_valid) else report_mismatch("speed_valid", 0, speed_valid);
        assert (!overflow) else report_mismatch("overflow", 0, overflow);
        assert (turns == 16'sd0) else report_mismatch("turns", 0, 32'(turns));
        assert (wr_n) else report_mismatch("wr_n", 1, wr_n);
        assert (sample_n) else report_mismatch("sample_n", 1, sample_n);
        assert (sclk) else report_mismatch("sclk", 1, sclk);
    endtask

    task automatic wait_angle_update();
        int n;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clock);
            if (angle_valid) begin
                return;
            end
        end
        timeouts++;
        $display("t=%0t timed out waiting for an angle update", $time);
    endtask

    task automatic wait_speed_count(input int target);
        int n;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clock);
            if (speed_updates >= target) begin
                return;
            end
        end
        timeouts++;
        $display("t=%0t timed out waiting for the last speed update", $time);
    endtask

    always @(negedge sample_n) begin
        cap_angle <= model_angle;
        cap_speed <= model_speed;
        cap_fault <= model_fault;
    end

    // The frame that starts now carries whatever the model held at SAMPLE
    always @(negedge wr_n) begin
        if (rst_n) begin
            if ({a1, a0} == 2'b00) begin
                angle_q.push_back({cap_angle, cap_fault});
            end else if ({a1, a0} == 2'b01) begin
                speed_q.push_back({cap_speed, cap_fault});
            end else begin
                report_problem("frame started with an unknown register address");
            end
        end
    end

    always @(negedge clock) begin
        logic [23:0] expected;
        // The converter reset pin follows the system reset in and out of reset
        assert (res_reset_n == rst_n)
            else report_mismatch("res_reset_n", 32'(rst_n), res_reset_n);
        if (rst_n) begin
            if (prev_wr_n && !wr_n) begin
                assert (sample_n && sample_done)
                    else report_problem("wr_n fell before a SAMPLE pulse had completed");
                sample_done = 1'b0;
            end
            if (!prev_sample_n && sample_n) begin
                sample_done = 1'b1;
            end
            assert (!wr_n || sclk) else report_problem("sclk low while wr_n was high");
            if (!wr_n && !prev_wr_n) begin
                assert ({a1, a0} == prev_addr) else report_problem("a1/a0 moved inside a frame");
            end
            assert ({re1, re0} == `RES_RESOLUTION)
                else report_mismatch("re1/re0", `RES_RESOLUTION, {re1, re0});
            assert (!sdi) else report_mismatch("sdi", 0, sdi);
            assert (!(overflow && !prev_overflow)) else report_mismatch("overflow", 0, overflow);
            if (angle_valid) begin
                angles_since_speed++;
                if (angle_q.size() == 0) begin
                    report_problem("angle_valid without any angle frame read");
                end else begin
                    expected = angle_q.pop_front();
                    assert (angle == expected[23:8])
                        else report_mismatch("angle", expected[23:8], angle);
                    assert (fault == expected[7:0])
                        else report_mismatch("fault", expected[7:0], fault);
                    // Turn rule applied to the previous and the new top quadrant bits
                    if (have_prev && prev_angle[15:14] == 2'b11 && expected[23:22] == 2'b00) begin
                        exp_turns++;
                        wraps_up++;
                    end else if (have_prev && prev_angle[15:14] == 2'b00 &&
                                 expected[23:22] == 2'b11) begin
                        exp_turns--;
                        wraps_down++;
                    end
                    prev_angle = expected[23:8];
                    have_prev  = 1'b1;
                    assert (turns == 16'(exp_turns))
                        else report_mismatch("turns", 32'(exp_turns), 32'(turns));
                end
            end
            if (speed_valid) begin
                speed_updates++;
                assert (angles_since_speed == `RES_SPEED_EVERY)
                    else report_mismatch("angle updates per speed update",
                                         `RES_SPEED_EVERY, angles_since_speed);
                angles_since_speed = 0;
                if (speed_q.size() == 0) begin
                    report_problem("speed_valid without any speed frame read");
                end else begin
                    expected = speed_q.pop_front();
                    assert (speed == expected[23:8])
                        else report_mismatch("speed", expected[23:8], speed);
                    assert (fault == expected[7:0])
                        else report_mismatch("fault", expected[7:0], fault);
                end
            end
        end
        prev_wr_n     = wr_n;
        prev_sample_n = sample_n;
        prev_overflow = overflow;
        prev_addr     = {a1, a0};
    end

    initial begin
        int i;
        rst_n       = 1'b0;
        enable      = 1'b0;
        model_angle = '0;
        model_speed = '0;
        model_fault = '0;
        lfsr        = LFSR_SEED;
        repeat (8) @(negedge clock);
        rst_n = 1'b1;
        repeat (4) @(negedge clock);
        check_idle_state();
        // The model values change right after each angle update
        for (i = 0; i < ANGLE_UPDATES && timeouts == 0; i++) begin
            load_model_values(i);
            enable = 1'b1;
            wait_angle_update();
        end
        if (timeouts == 0) begin
            wait_speed_count(ANGLE_UPDATES / `RES_SPEED_EVERY);
        end
        assert (speed_updates == ANGLE_UPDATES / `RES_SPEED_EVERY)
            else report_mismatch("speed update count", ANGLE_UPDATES / `RES_SPEED_EVERY,
                                 speed_updates);
        assert (wraps_up > 0 && wraps_down > 0)
            else report_problem("angle sequence never crossed zero in both directions");
        $display("value errors %0d, other errors %0d, timeouts %0d",
                 value_errors, other_errors, timeouts);
        if (value_errors + other_errors + timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+design
design/resolver_pkg.sv
design/read_scheduler.sv
design/ad2s1210_reader.sv
design/sample_fifo.sv
design/position_tracker.sv
design/resolver_top.sv
verification/ad2s1210_model.sv
verification/resolver_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := resolver_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
LOG       := sim.log

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)

.PHONY: all run clean

all: run

# The binary is rebuilt only when a source, header or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
